// File: design/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    // Address decoded as a register number or as access/privilege fields
    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic [1:0] access;
            logic [1:0] priv;
            logic [7:0] index;
        } f;
    } csr_addr_u;

    localparam logic [1:0] CSR_ACCESS_RO = 2'b11;

    localparam logic [11:0] CSR_CYCLE    = 12'hC00;
    localparam logic [11:0] CSR_TIME     = 12'hC01;
    localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [11:0] CSR_TIMEH    = 12'hC81;
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MIE      = 12'h304;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MIP      = 12'h344;
    localparam logic [11:0] CSR_MCYCLE   = 12'hB00;
    localparam logic [11:0] CSR_MCYCLEH  = 12'hB80;

    // Bit positions in mstatus, mie and mip
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int IRQ_MSI_BIT      = 3;
    localparam int IRQ_MTI_BIT      = 7;

    localparam logic [1:0] MTVEC_VECTORED = 2'b01;

    localparam logic [31:0] CAUSE_MTI     = 32'h8000_0007;
    localparam logic [31:0] CAUSE_MSI     = 32'h8000_0003;
    // ECALL from M lands on 11, base plus mode
    localparam logic [31:0] CAUSE_ECALL_U = 32'd8;

    // RV32IM, MXL = 1
    localparam logic [31:0] MISA_VALUE = 32'h4000_1100;

    typedef struct packed {
        logic        valid;
        logic [31:0] cause;
    } trap_info_t;

    typedef struct packed {
        priv_mode_e  mode;
        logic        mie;
        logic        mpie;
        priv_mode_e  mpp;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mscratch;
        logic        mtie;
        logic        msie;
        logic        mtip;
        logic        msip;
    } csr_state_t;

    typedef struct packed {
        logic        en;
        csr_addr_u   addr;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic        take;
        logic [31:0] cause;
        logic [31:0] pc;
        logic        mret;
        logic        mtip_upd;
        logic        mtip_val;
    } trap_event_t;

endpackage

`default_nettype wire

// File: design/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access import csr_pkg::*; (
    input  wire csr_state_t  state_i,
    input  wire logic        valid_i,
    input  wire logic        is_new_i,
    input  wire csr_cmd_e    cmd_i,
    input  wire logic [31:0] imm_i,
    input  wire logic [31:0] op1_i,
    input  wire logic [63:0] cycle_i,
    input  wire logic [63:0] time_i,
    output logic [31:0]      rdata_o,
    output csr_write_t       wr_o
);

    csr_addr_u   addr;
    logic        can_access;
    logic        can_write;
    logic        cmd_is_write;
    logic [31:0] mux_word;
    logic [31:0] wdata;

    assign addr = imm_i[11:0];

    // Privilege field must not exceed current mode
    assign can_access   = addr.f.priv <= state_i.mode;
    assign can_write    = can_access && (addr.f.access != CSR_ACCESS_RO);
    assign cmd_is_write = (cmd_i == CMD_WRITE) || (cmd_i == CMD_SET) || (cmd_i == CMD_CLEAR);

    always_comb begin
        mux_word = '0;
        case (addr.raw)
            CSR_CYCLE, CSR_MCYCLE:   mux_word = cycle_i[31:0];
            CSR_CYCLEH, CSR_MCYCLEH: mux_word = cycle_i[63:32];
            CSR_TIME:                mux_word = time_i[31:0];
            CSR_TIMEH:               mux_word = time_i[63:32];
            CSR_MSTATUS: begin
                mux_word[MSTATUS_MIE_BIT]          = state_i.mie;
                mux_word[MSTATUS_MPIE_BIT]         = state_i.mpie;
                mux_word[MSTATUS_MPP_LSB +: 2]     = state_i.mpp;
            end
            CSR_MISA:                mux_word = MISA_VALUE;
            CSR_MIE: begin
                mux_word[IRQ_MTI_BIT] = state_i.mtie;
                mux_word[IRQ_MSI_BIT] = state_i.msie;
            end
            CSR_MIP: begin
                mux_word[IRQ_MTI_BIT] = state_i.mtip;
                mux_word[IRQ_MSI_BIT] = state_i.msip;
            end
            CSR_MTVEC:               mux_word = state_i.mtvec;
            CSR_MSCRATCH:            mux_word = state_i.mscratch;
            CSR_MEPC:                mux_word = state_i.mepc;
            CSR_MCAUSE:              mux_word = state_i.mcause;
            default:                 mux_word = '0;
        endcase
    end

    assign rdata_o = can_access ? mux_word : '0;

    // Read-modify-write on the current value
    always_comb begin
        case (cmd_i)
            CMD_WRITE: wdata = op1_i;
            CMD_SET:   wdata = rdata_o | op1_i;
            CMD_CLEAR: wdata = rdata_o & ~op1_i;
            default:   wdata = '0;
        endcase
    end

    // Write lands in the B cycle only
    assign wr_o.en   = valid_i && !is_new_i && cmd_is_write && can_write;
    assign wr_o.addr = addr;
    assign wr_o.data = wdata;

endmodule

`default_nettype wire

// File: design/csr_machine_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs import csr_pkg::*; #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire csr_write_t  wr_i,
    input  wire trap_event_t evt_i,
    output csr_state_t       state_o
);

    csr_state_t  state_q;
    logic [31:0] wd;

    assign wd      = wr_i.data;
    assign state_o = state_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= '0;
            state_q.mode  <= PRIV_M;
            state_q.mpp   <= PRIV_M;
            state_q.mtvec <= MTVEC_RESET;
        end else begin
            // CSR write from the B cycle
            if (wr_i.en) begin
                case (wr_i.addr.raw)
                    CSR_MSTATUS: begin
                        state_q.mie  <= wd[MSTATUS_MIE_BIT];
                        state_q.mpie <= wd[MSTATUS_MPIE_BIT];
                        // Only U and M exist, other values fall back to U
                        state_q.mpp  <= (wd[MSTATUS_MPP_LSB +: 2] == PRIV_M) ? PRIV_M : PRIV_U;
                    end
                    CSR_MIE: begin
                        state_q.mtie <= wd[IRQ_MTI_BIT];
                        state_q.msie <= wd[IRQ_MSI_BIT];
                    end
                    // mtip follows the timer, so only msip is writable
                    CSR_MIP:      state_q.msip     <= wd[IRQ_MSI_BIT];
                    CSR_MTVEC:    state_q.mtvec    <= wd;
                    CSR_MSCRATCH: state_q.mscratch <= wd;
                    CSR_MEPC:     state_q.mepc     <= {wd[31:2], 2'b00};
                    CSR_MCAUSE:   state_q.mcause   <= wd;
                    default: begin
                    end
                endcase
            end

            if (evt_i.mtip_upd) begin
                state_q.mtip <= evt_i.mtip_val;
            end

            // Trap entry and MRET from the A cycle
            if (evt_i.take) begin
                state_q.mepc   <= evt_i.pc;
                state_q.mcause <= evt_i.cause;
                state_q.mpie   <= state_q.mie;
                state_q.mie    <= 1'b0;
                state_q.mpp    <= state_q.mode;
                state_q.mode   <= PRIV_M;
                if (evt_i.cause == CAUSE_MSI) begin
                    state_q.msip <= 1'b0;
                end
                if (evt_i.cause == CAUSE_MTI) begin
                    state_q.mtip <= 1'b0;
                end
            end else if (evt_i.mret) begin
                state_q.mie  <= state_q.mpie;
                state_q.mpie <= 1'b1;
                state_q.mode <= state_q.mpp;
                state_q.mpp  <= PRIV_U;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import csr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire csr_state_t  state_i,
    input  wire logic        valid_i,
    input  wire logic        is_new_i,
    input  wire csr_cmd_e    cmd_i,
    input  wire logic [31:0] pc_i,
    input  wire trap_info_t  trap_info_i,
    input  wire logic [63:0] mtime_i,
    input  wire logic [63:0] mtimecmp_i,
    input  wire logic [31:0] rdata_i,
    output trap_event_t      evt_o,
    output logic [31:0]      rdata_o,
    output logic             is_stall_o,
    output logic             trap_o,
    output logic [31:0]      trap_vector_o
);

    logic        a_cycle;
    logic        global_ie;
    logic        msi_pend;
    logic        mti_pend;
    logic        irq;
    logic        take_trap;
    logic        do_mret;
    logic        cmd_is_write;
    logic        last_trap_q;
    logic [31:0] irq_cause;
    logic [31:0] exc_cause;
    logic [31:0] cause;
    logic [31:0] base;
    logic [31:0] vector;

    assign a_cycle = valid_i && is_new_i;

    // U mode always takes machine interrupts
    assign global_ie = (state_i.mode == PRIV_U) || state_i.mie;
    assign msi_pend  = state_i.msip && state_i.msie;
    assign mti_pend  = state_i.mtip && state_i.mtie;
    assign irq       = global_ie && (msi_pend || mti_pend);
    assign irq_cause = msi_pend ? CAUSE_MSI : CAUSE_MTI;

    assign exc_cause = trap_info_i.cause + ((cmd_i == CMD_ECALL) ? {30'b0, state_i.mode} : 32'b0);
    assign cause     = trap_info_i.valid ? exc_cause : irq_cause;
    assign take_trap = trap_info_i.valid || irq;
    assign do_mret   = !take_trap && (cmd_i == CMD_MRET);

    // Vectored mode offsets interrupts only
    assign base   = {state_i.mtvec[31:2], 2'b00};
    assign vector = (state_i.mtvec[1:0] == MTVEC_VECTORED && cause[31])
                  ? base + {cause[29:0], 2'b00}
                  : base;

    assign cmd_is_write = (cmd_i == CMD_WRITE) || (cmd_i == CMD_SET) || (cmd_i == CMD_CLEAR);
    assign is_stall_o   = a_cycle && (take_trap || cmd_i == CMD_MRET || cmd_is_write);

    assign evt_o.take     = a_cycle && take_trap;
    assign evt_o.cause    = cause;
    assign evt_o.pc       = pc_i;
    assign evt_o.mret     = a_cycle && do_mret;
    assign evt_o.mtip_upd = a_cycle && !take_trap;
    assign evt_o.mtip_val = mtime_i >= mtimecmp_i;

    assign trap_o = valid_i && !is_new_i && last_trap_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_trap_q   <= 1'b0;
            trap_vector_o <= '1;
        end else begin
            last_trap_q <= a_cycle && (take_trap || do_mret);
            if (a_cycle) begin
                if (take_trap) begin
                    trap_vector_o <= vector;
                end else if (do_mret) begin
                    trap_vector_o <= state_i.mepc;
                end else begin
                    trap_vector_o <= '1;
                end
            end
        end
    end

    // Read word captured at the A edge
    always_ff @(posedge clk) begin
        if (a_cycle) begin
            rdata_o <= rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: design/csr_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage_top import csr_pkg::*; #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire logic        valid_i,
    input  wire logic        is_new_i,
    input  wire logic [31:0] pc_i,
    input  wire csr_cmd_e    cmd_i,
    input  wire logic [31:0] imm_i,
    input  wire logic [31:0] op1_i,
    input  wire trap_info_t  trap_info_i,
    input  wire logic [63:0] cycle_i,
    input  wire logic [63:0] time_i,
    input  wire logic [63:0] mtime_i,
    input  wire logic [63:0] mtimecmp_i,
    output logic [31:0]      rdata_o,
    output logic             is_stall_o,
    output logic             trap_o,
    output logic [31:0]      trap_vector_o
);

    csr_state_t  state;
    csr_write_t  wr;
    trap_event_t evt;
    logic [31:0] rd_word;

    csr_access u_access (
        .state_i  (state),
        .valid_i  (valid_i),
        .is_new_i (is_new_i),
        .cmd_i    (cmd_i),
        .imm_i    (imm_i),
        .op1_i    (op1_i),
        .cycle_i  (cycle_i),
        .time_i   (time_i),
        .rdata_o  (rd_word),
        .wr_o     (wr)
    );

    csr_machine_regs #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (wr),
        .evt_i   (evt),
        .state_o (state)
    );

    trap_ctrl u_trap (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .state_i       (state),
        .valid_i       (valid_i),
        .is_new_i      (is_new_i),
        .cmd_i         (cmd_i),
        .pc_i          (pc_i),
        .trap_info_i   (trap_info_i),
        .mtime_i       (mtime_i),
        .mtimecmp_i    (mtimecmp_i),
        .rdata_i       (rd_word),
        .evt_o         (evt),
        .rdata_o       (rdata_o),
        .is_stall_o    (is_stall_o),
        .trap_o        (trap_o),
        .trap_vector_o (trap_vector_o)
    );

endmodule

`default_nettype wire

// File: test/csr_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage_chk import csr_pkg::*; (
    input wire logic     clk,
    input wire logic     rst_n_i,
    input wire logic     valid_i,
    input wire logic     is_new_i,
    input wire csr_cmd_e cmd_i,
    input wire logic     stall_i,
    input wire logic     trap_i
);

    int fail_count = 0;

    // Trap strobe belongs to the B cycle
    a_no_trap_in_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        trap_i |-> !(valid_i && is_new_i))
    else begin
        $error("trap_o high during an A cycle");
        fail_count++;
    end

    a_stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |-> valid_i)
    else begin
        $error("is_stall_o high without valid_i");
        fail_count++;
    end

    // mret always redirects in its B cycle
    a_mret_traps: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_i && is_new_i && cmd_i == CMD_MRET) |=> trap_i)
    else begin
        $error("trap_o missing after an mret A cycle");
        fail_count++;
    end

endmodule

bind csr_stage_top csr_stage_chk u_chk (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .is_new_i (is_new_i),
    .cmd_i    (cmd_i),
    .stall_i  (is_stall_o),
    .trap_i   (trap_o)
);

`default_nettype wire

// File: test/csr_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage_tb import csr_pkg::*; ();

    localparam logic [31:0] MTVEC_BASE     = 32'h0000_0100;
    localparam int          TIMEOUT_CYCLES = 2000;
    // RV32IM: MXL = 1 in the top bits, one bit per extension letter
    localparam logic [31:0] MISA_EXPECT    = (32'd1 << 30) | (32'd1 << 8) | (32'd1 << 12);

    logic        clk;
    logic        rst_n_i;
    logic        valid_i;
    logic        is_new_i;
    logic [31:0] pc_i;
    csr_cmd_e    cmd_i;
    logic [31:0] imm_i;
    logic [31:0] op1_i;
    trap_info_t  trap_info_i;
    logic [63:0] cycle_i;
    logic [63:0] time_i;
    logic [63:0] mtime_i;
    logic [63:0] mtimecmp_i;
    logic [31:0] rdata_o;
    logic        is_stall_o;
    logic        trap_o;
    logic [31:0] trap_vector_o;

    int          error_count;
    int          check_count;
    int          cycle_count;
    logic [31:0] cur_pc;
    logic [31:0] last_pc;
    logic        stall_seen;
    logic        trap_seen;
    logic [31:0] scratch_model;

    csr_stage_top #(
        .MTVEC_RESET (MTVEC_BASE)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERR %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // A cycle then B cycle, entered and left 1 ns after a rising edge
    task automatic run_instr(input csr_cmd_e cmd, input logic [11:0] addr,
                             input logic [31:0] op1, input logic exc);
        valid_i           = 1'b1;
        is_new_i          = 1'b1;
        cmd_i             = cmd;
        imm_i             = {20'h0, addr};
        op1_i             = op1;
        pc_i              = cur_pc;
        trap_info_i.valid = exc;
        trap_info_i.cause = exc ? CAUSE_ECALL_U : 32'h0;
        last_pc           = cur_pc;
        cur_pc            = cur_pc + 32'd4;
        #1;
        stall_seen = is_stall_o;
        @(posedge clk);
        #1;
        is_new_i = 1'b0;
        #1;
        trap_seen = trap_o;
        @(posedge clk);
        #1;
        valid_i     = 1'b0;
        cmd_i       = CMD_NONE;
        trap_info_i = '0;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        run_instr(CMD_NONE, addr, 32'h0, 1'b0);
        data = rdata_o;
    endtask

    task automatic test_reset_values();
        logic [31:0] rd;
        check_word("reset trap_vector_o", 32'hFFFF_FFFF, trap_vector_o);
        check_word("reset trap_o", 32'h0, trap_o);
        check_word("reset is_stall_o", 32'h0, is_stall_o);
        read_csr(CSR_MSTATUS, rd);
        check_word("reset mstatus", 32'h0000_1800, rd);
        read_csr(CSR_MTVEC, rd);
        check_word("reset mtvec", MTVEC_BASE, rd);
    endtask

    task automatic test_rmw();
        logic [31:0] wval;
        logic [31:0] sval;
        logic [31:0] cval;
        logic [31:0] rd;
        wval = $urandom;
        sval = $urandom;
        cval = $urandom;
        run_instr(CMD_WRITE, CSR_MSCRATCH, wval, 1'b0);
        check_word("rmw write stall", 32'h1, stall_seen);
        scratch_model = wval;
        read_csr(CSR_MSCRATCH, rd);
        check_word("rmw after write", scratch_model, rd);
        run_instr(CMD_SET, CSR_MSCRATCH, sval, 1'b0);
        check_word("rmw set old value", scratch_model, rdata_o);
        scratch_model = scratch_model | sval;
        read_csr(CSR_MSCRATCH, rd);
        check_word("rmw after set", scratch_model, rd);
        run_instr(CMD_CLEAR, CSR_MSCRATCH, cval, 1'b0);
        scratch_model = scratch_model & ~cval;
        read_csr(CSR_MSCRATCH, rd);
        check_word("rmw after clear", scratch_model, rd);
    endtask

    task automatic test_readonly();
        logic [31:0] rd;
        run_instr(CMD_WRITE, CSR_MISA, $urandom, 1'b0);
        read_csr(CSR_MISA, rd);
        check_word("readonly misa", MISA_EXPECT, rd);
        cycle_i = {$urandom, $urandom};
        time_i  = {$urandom, $urandom};
        read_csr(CSR_CYCLE, rd);
        check_word("readonly cycle", cycle_i[31:0], rd);
        read_csr(CSR_CYCLEH, rd);
        check_word("readonly cycleh", cycle_i[63:32], rd);
        read_csr(CSR_TIME, rd);
        check_word("readonly time", time_i[31:0], rd);
    endtask

    task automatic test_ecall_m();
        logic [31:0] epc;
        logic [31:0] rd;
        // mie set and mpp = U, so trap entry has to change both
        run_instr(CMD_WRITE, CSR_MSTATUS, 32'd1 << 3, 1'b0);
        run_instr(CMD_ECALL, 12'h0, 32'h0, 1'b1);
        epc = last_pc;
        check_word("ecall_m stall", 32'h1, stall_seen);
        check_word("ecall_m trap", 32'h1, trap_seen);
        check_word("ecall_m vector", MTVEC_BASE, trap_vector_o);
        read_csr(CSR_MEPC, rd);
        check_word("ecall_m mepc", epc, rd);
        read_csr(CSR_MCAUSE, rd);
        check_word("ecall_m mcause", 32'd8 + 32'd3, rd);
        read_csr(CSR_MSTATUS, rd);
        check_word("ecall_m mpp", 32'd3, {30'h0, rd[12:11]});
        check_word("ecall_m mie", 32'h0, rd[3]);
        check_word("ecall_m mpie", 32'h1, rd[7]);
    endtask

    task automatic test_mret_user();
        logic [31:0] target;
        logic [31:0] epc;
        logic [31:0] rd;
        target = 32'h0001_0000 | ($urandom & 32'h0000_FFFC);
        // mpp = U, interrupts off
        run_instr(CMD_WRITE, CSR_MSTATUS, 32'h0, 1'b0);
        run_instr(CMD_WRITE, CSR_MEPC, target, 1'b0);
        run_instr(CMD_MRET, 12'h0, 32'h0, 1'b0);
        check_word("mret stall", 32'h1, stall_seen);
        check_word("mret trap", 32'h1, trap_seen);
        check_word("mret vector", target, trap_vector_o);
        cur_pc = target;

        // Now in U mode
        read_csr(CSR_MSCRATCH, rd);
        check_word("user mscratch denied", 32'h0, rd);
        read_csr(CSR_CYCLE, rd);
        check_word("user cycle", cycle_i[31:0], rd);
        run_instr(CMD_WRITE, CSR_MSCRATCH, ~scratch_model, 1'b0);
        run_instr(CMD_WRITE, CSR_MTVEC, 32'h0000_0300, 1'b0);

        run_instr(CMD_ECALL, 12'h0, 32'h0, 1'b1);
        epc = last_pc;
        check_word("ecall_u trap", 32'h1, trap_seen);
        check_word("ecall_u vector", MTVEC_BASE, trap_vector_o);
        read_csr(CSR_MCAUSE, rd);
        check_word("ecall_u mcause", 32'd8, rd);
        read_csr(CSR_MEPC, rd);
        check_word("ecall_u mepc", epc, rd);
        read_csr(CSR_MSCRATCH, rd);
        check_word("user mscratch kept", scratch_model, rd);
        read_csr(CSR_MTVEC, rd);
        check_word("user mtvec kept", MTVEC_BASE, rd);
        read_csr(CSR_MSTATUS, rd);
        check_word("ecall_u mpp", 32'd0, {30'h0, rd[12:11]});
    endtask

    task automatic test_timer_irq();
        logic [31:0] epc;
        logic [31:0] rd;
        run_instr(CMD_WRITE, CSR_MTVEC, 32'h0000_0201, 1'b0);
        run_instr(CMD_WRITE, CSR_MIE, 32'd1 << 7, 1'b0);
        run_instr(CMD_SET, CSR_MSTATUS, 32'd1 << 3, 1'b0);
        mtimecmp_i = {32'h0000_0001, $urandom};
        mtime_i    = mtimecmp_i + 64'($urandom % 16);

        // Refreshes mtip without trapping
        run_instr(CMD_NONE, 12'h0, 32'h0, 1'b0);
        check_word("timer noop stall", 32'h0, stall_seen);
        check_word("timer noop trap", 32'h0, trap_seen);

        run_instr(CMD_NONE, 12'h0, 32'h0, 1'b0);
        epc = last_pc;
        check_word("timer stall", 32'h1, stall_seen);
        check_word("timer trap", 32'h1, trap_seen);
        check_word("timer vector", 32'h0000_0200 + 32'd4 * 32'd7, trap_vector_o);
        read_csr(CSR_MCAUSE, rd);
        check_word("timer mcause", (32'd1 << 31) | 32'd7, rd);
        read_csr(CSR_MEPC, rd);
        check_word("timer mepc", epc, rd);
        mtime_i = 64'h0;
    endtask

    initial begin
        void'($urandom(32'h68b8));
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        is_new_i    = 1'b0;
        pc_i        = 32'h0;
        cmd_i       = CMD_NONE;
        imm_i       = 32'h0;
        op1_i       = 32'h0;
        trap_info_i = '0;
        cycle_i     = 64'h0;
        time_i      = 64'h0;
        mtime_i     = 64'h0;
        mtimecmp_i  = '1;
        error_count = 0;
        check_count = 0;
        cur_pc      = 32'h0000_1000;
        last_pc     = 32'h0;
        stall_seen  = 1'b0;
        trap_seen   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        test_reset_values();
        test_rmw();
        test_readonly();
        test_ecall_m();
        test_mret_user();
        test_timer_irq();

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, DUT.u_chk.fail_count);
        if (error_count == 0 && DUT.u_chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/csr_pkg.sv
design/csr_access.sv
design/csr_machine_regs.sv
design/trap_ctrl.sv
design/csr_stage_top.sv
test/csr_stage_chk.sv
test/csr_stage_tb.sv

// File: Bender.yml
package:
  name: csr_stage

sources:
  - design/csr_pkg.sv
  - design/csr_access.sv
  - design/csr_machine_regs.sv
  - design/trap_ctrl.sv
  - design/csr_stage_top.sv
  - target: test
    files:
      - test/csr_stage_chk.sv
      - test/csr_stage_tb.sv
